//--- hw/rv_core.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_core import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    output logic [`RV_XLEN-1:0]   imem_addr,
    input  logic [`RV_XLEN-1:0]   imem_data,
    output logic [`RV_XLEN-1:0]   dmem_addr,
    output logic [`RV_XLEN-1:0]   dmem_wdata,
    output logic                  dmem_we,
    output logic                  dmem_re,
    input  logic [`RV_XLEN-1:0]   dmem_rdata,
    output logic                  retire_valid,
    output logic [`RV_XLEN-1:0]   retire_pc,
    output logic                  retire_we,
    output logic [`RV_REG_AW-1:0] retire_rd,
    output logic [`RV_XLEN-1:0]   retire_data
);

    logic                  fd_valid;
    logic [`RV_XLEN-1:0]   fd_pc;
    instr_u                fd_instr;
    logic                  stall, redirect;
    logic [`RV_XLEN-1:0]   redirect_pc;
    logic [`RV_REG_AW-1:0] d_rs1, d_rs2;
    logic [`RV_XLEN-1:0]   rf_rdata1, rf_rdata2;
    de_bus_t               de_bus;
    em_bus_t               em_bus;
    fwd_sel_e              fwd_a, fwd_b;
    logic                  wb_we;
    logic [`RV_REG_AW-1:0] wb_rd;
    logic [`RV_XLEN-1:0]   wb_data;

    // ----------------------------------------
    // front end
    // ----------------------------------------
    rv_fetch rv_fetch_inst (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .fd_valid    (fd_valid),
        .fd_pc       (fd_pc),
        .fd_instr    (fd_instr)
    );

    rv_decode rv_decode_inst (
        .clk      (clk),
        .rst      (rst),
        .fd_valid (fd_valid),
        .fd_pc    (fd_pc),
        .fd_instr (fd_instr),
        .stall    (stall),
        .redirect (redirect),
        .rs1      (d_rs1),
        .rs2      (d_rs2),
        .rdata1   (rf_rdata1),
        .rdata2   (rf_rdata2),
        .de_bus   (de_bus)
    );

    rv_regfile rv_regfile_inst (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (d_rs1),
        .raddr2 (d_rs2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (wb_we),
        .waddr  (wb_rd),
        .wdata  (wb_data)
    );

    rv_hazard rv_hazard_inst (
        .d_rs1    (d_rs1),
        .d_rs2    (d_rs2),
        .e_rs1    (de_bus.rs1),
        .e_rs2    (de_bus.rs2),
        .e_rd     (de_bus.rd),
        .m_rd     (em_bus.rd),
        .w_rd     (wb_rd),
        .e_mem_re (de_bus.ctrl.mem_re),
        .m_reg_we (em_bus.reg_we),
        .w_reg_we (wb_we),
        .stall    (stall),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b)
    );

    // ----------------------------------------
    // back end
    // ----------------------------------------
    rv_execute rv_execute_inst (
        .clk         (clk),
        .rst         (rst),
        .de_bus      (de_bus),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .m_fwd_data  (em_bus.result),   // never a load, the stall sees to that
        .w_fwd_data  (wb_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .em_bus      (em_bus)
    );

    // memory stage is just the data port
    assign dmem_addr  = em_bus.result;
    assign dmem_wdata = em_bus.store_data;
    assign dmem_we    = em_bus.valid && em_bus.mem_we;
    assign dmem_re    = em_bus.valid && em_bus.mem_re;

    rv_writeback rv_writeback_inst (
        .clk          (clk),
        .rst          (rst),
        .em_bus       (em_bus),
        .load_data    (dmem_rdata),
        .reg_we       (wb_we),
        .rd           (wb_rd),
        .wdata        (wb_data),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc)
    );

    assign retire_we   = wb_we;
    assign retire_rd   = wb_rd;
    assign retire_data = wb_data;

endmodule

//--- hw/rv_decode.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_decode import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  fd_valid,
    input  logic [`RV_XLEN-1:0]   fd_pc,
    input  instr_u                fd_instr,
    input  logic                  stall,
    input  logic                  redirect,
    output logic [`RV_REG_AW-1:0] rs1,
    output logic [`RV_REG_AW-1:0] rs2,
    input  logic [`RV_XLEN-1:0]   rdata1,
    input  logic [`RV_XLEN-1:0]   rdata2,
    output de_bus_t               de_bus
);

    ctrl_t               ctrl;
    logic                legal;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [2:0]          f3;

    function automatic alu_op_e alu_sel(input logic [2:0] funct3, input logic alt);
        alu_op_e op;
        case (funct3)
            `RV_F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
            `RV_F3_SLL:  op = ALU_SLL;
            `RV_F3_SLT:  op = ALU_SLT;
            `RV_F3_SLTU: op = ALU_SLTU;
            `RV_F3_XOR:  op = ALU_XOR;
            `RV_F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
            `RV_F3_OR:   op = ALU_OR;
            default:     op = ALU_AND;
        endcase
        return op;
    endfunction

    assign f3  = fd_instr.r.funct3;
    assign rs1 = fd_instr.r.rs1;
    assign rs2 = fd_instr.r.rs2;

    // ----------------------------------------
    // immediates
    // ----------------------------------------
    assign imm_i = {{20{fd_instr.i.imm[11]}}, fd_instr.i.imm};
    assign imm_s = {{20{fd_instr.s.imm_hi[6]}}, fd_instr.s.imm_hi, fd_instr.s.imm_lo};
    assign imm_b = {{19{fd_instr.b.imm12}}, fd_instr.b.imm12, fd_instr.b.imm11,
                    fd_instr.b.imm10_5, fd_instr.b.imm4_1, 1'b0};
    assign imm_u = {fd_instr.u.imm31_12, 12'b0};
    assign imm_j = {{11{fd_instr.j.imm20}}, fd_instr.j.imm20, fd_instr.j.imm19_12,
                    fd_instr.j.imm11, fd_instr.j.imm10_1, 1'b0};

    // ----------------------------------------
    // control decode
    // ----------------------------------------
    always_comb begin
        ctrl  = '0;
        imm   = '0;
        legal = 1'b1;
        case (fd_instr.r.opcode)
            `RV_OP_LUI: begin
                ctrl.reg_we = 1'b1;
                ctrl.is_lui = 1'b1;
                imm         = imm_u;
            end
            `RV_OP_JAL: begin
                ctrl.reg_we = 1'b1;
                ctrl.is_jal = 1'b1;
                imm         = imm_j;
            end
            `RV_OP_BRANCH: begin
                ctrl.is_branch = 1'b1;
                ctrl.branch_ne = (f3 == `RV_F3_BNE);
                imm            = imm_b;
                legal          = (f3 == `RV_F3_BEQ) || (f3 == `RV_F3_BNE);
            end
            `RV_OP_LOAD: begin // word only
                ctrl.mem_re  = 1'b1;
                ctrl.reg_we  = 1'b1;
                ctrl.use_imm = 1'b1;
                imm          = imm_i;
            end
            `RV_OP_STORE: begin
                ctrl.mem_we  = 1'b1;
                ctrl.use_imm = 1'b1;
                imm          = imm_s;
            end
            `RV_OP_IMM: begin
                ctrl.reg_we  = 1'b1;
                ctrl.use_imm = 1'b1;
                // srai keeps its funct7 in the upper immediate bits
                ctrl.alu_op  = alu_sel(f3, (f3 == `RV_F3_SR) && fd_instr.r.funct7[5]);
                imm          = imm_i;
            end
            `RV_OP_REG: begin
                ctrl.reg_we = 1'b1;
                ctrl.alu_op = alu_sel(f3, fd_instr.r.funct7[5]);
            end
            default: legal = 1'b0; // unknown, becomes a bubble
        endcase
    end

    // ----------------------------------------
    // decode to execute buffer
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            de_bus <= '0;
        end else if (stall || redirect || !(fd_valid && legal)) begin
            de_bus <= '0; // bubble, no writes
        end else begin
            de_bus.valid  <= 1'b1;
            de_bus.pc     <= fd_pc;
            de_bus.rs1    <= rs1;
            de_bus.rs2    <= rs2;
            de_bus.rd     <= fd_instr.r.rd;
            de_bus.rdata1 <= rdata1;
            de_bus.rdata2 <= rdata2;
            de_bus.imm    <= imm;
            de_bus.ctrl   <= ctrl;
        end
    end

endmodule

//--- hw/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

`define RV_XLEN      32
`define RV_REG_AW    5
`define RV_RESET_PC  32'h0000_0000

// ----------------------------------------
// opcodes of the kept RV32I subset
// ----------------------------------------
`define RV_OP_LUI     7'b0110111
`define RV_OP_JAL     7'b1101111
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_IMM     7'b0010011
`define RV_OP_REG     7'b0110011

// alu funct3
`define RV_F3_ADD   3'b000
`define RV_F3_SLL   3'b001
`define RV_F3_SLT   3'b010
`define RV_F3_SLTU  3'b011
`define RV_F3_XOR   3'b100
`define RV_F3_SR    3'b101   // srl / sra, split by funct7[5]
`define RV_F3_OR    3'b110
`define RV_F3_AND   3'b111

// branch funct3
`define RV_F3_BEQ   3'b000
`define RV_F3_BNE   3'b001

`endif

//--- hw/rv_execute.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_execute import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  de_bus_t             de_bus,
    input  fwd_sel_e            fwd_a,
    input  fwd_sel_e            fwd_b,
    input  logic [`RV_XLEN-1:0] m_fwd_data,
    input  logic [`RV_XLEN-1:0] w_fwd_data,
    output logic                redirect,
    output logic [`RV_XLEN-1:0] redirect_pc,
    output em_bus_t             em_bus
);

    logic [`RV_XLEN-1:0] op_a, rs2_val, op_b;
    logic [`RV_XLEN-1:0] alu_out, result;
    logic                taken;

    function automatic logic [`RV_XLEN-1:0] fwd_mux(input fwd_sel_e sel,
                                                    input logic [`RV_XLEN-1:0] reg_val);
        case (sel)
            FWD_MEM: return m_fwd_data;
            FWD_WB:  return w_fwd_data;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        op_a    = fwd_mux(fwd_a, de_bus.rdata1);
        rs2_val = fwd_mux(fwd_b, de_bus.rdata2);
    end

    assign op_b = de_bus.ctrl.use_imm ? de_bus.imm : rs2_val;

    // ----------------------------------------
    // alu
    // ----------------------------------------
    always_comb begin
        case (de_bus.ctrl.alu_op)
            ALU_SUB:  alu_out = op_a - op_b;
            ALU_SLL:  alu_out = op_a << op_b[4:0];
            ALU_SLT:  alu_out = `RV_XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU: alu_out = `RV_XLEN'(op_a < op_b);
            ALU_XOR:  alu_out = op_a ^ op_b;
            ALU_SRL:  alu_out = op_a >> op_b[4:0];
            ALU_SRA:  alu_out = $signed(op_a) >>> op_b[4:0];
            ALU_OR:   alu_out = op_a | op_b;
            ALU_AND:  alu_out = op_a & op_b;
            default:  alu_out = op_a + op_b;
        endcase
    end

    always_comb begin
        if (de_bus.ctrl.is_jal) begin
            result = de_bus.pc + `RV_XLEN'd4; // link value
        end else if (de_bus.ctrl.is_lui) begin
            result = de_bus.imm;
        end else begin
            result = alu_out;
        end
    end

    // ----------------------------------------
    // branch resolution
    // ----------------------------------------
    assign taken       = de_bus.ctrl.is_branch && ((op_a == rs2_val) != de_bus.ctrl.branch_ne);
    assign redirect    = de_bus.valid && (de_bus.ctrl.is_jal || taken);
    assign redirect_pc = de_bus.pc + de_bus.imm;

    // execute to memory buffer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            em_bus <= '0;
        end else begin
            em_bus.valid      <= de_bus.valid;
            em_bus.pc         <= de_bus.pc;
            em_bus.rd         <= de_bus.rd;
            em_bus.result     <= result;
            em_bus.store_data <= rs2_val;
            em_bus.reg_we     <= de_bus.valid && de_bus.ctrl.reg_we;
            em_bus.mem_we     <= de_bus.valid && de_bus.ctrl.mem_we;
            em_bus.mem_re     <= de_bus.valid && de_bus.ctrl.mem_re;
        end
    end

endmodule

//--- hw/rv_fetch.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_fetch import rv_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                stall,
    input  logic                redirect,
    input  logic [`RV_XLEN-1:0] redirect_pc,
    output logic [`RV_XLEN-1:0] imem_addr,
    input  logic [`RV_XLEN-1:0] imem_data,
    output logic                fd_valid,
    output logic [`RV_XLEN-1:0] fd_pc,
    output instr_u              fd_instr
);

    logic [`RV_XLEN-1:0] pc;

    assign imem_addr = pc; // memory answers in the same cycle

    // ----------------------------------------
    // program counter
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= `RV_RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc; // target fetched next cycle
        end else if (!stall) begin
            pc <= pc + `RV_XLEN'd4;
        end
    end

    // ----------------------------------------
    // fetch to decode buffer
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fd_valid <= 1'b0;
        end else if (redirect) begin
            fd_valid <= 1'b0; // kill the younger word
        end else if (!stall) begin
            fd_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && !redirect) begin
            fd_pc    <= pc;
            fd_instr <= imem_data;
        end
    end

endmodule

//--- hw/rv_hazard.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_hazard import rv_pkg::*; (
    input  logic [`RV_REG_AW-1:0] d_rs1,
    input  logic [`RV_REG_AW-1:0] d_rs2,
    input  logic [`RV_REG_AW-1:0] e_rs1,
    input  logic [`RV_REG_AW-1:0] e_rs2,
    input  logic [`RV_REG_AW-1:0] e_rd,
    input  logic [`RV_REG_AW-1:0] m_rd,
    input  logic [`RV_REG_AW-1:0] w_rd,
    input  logic                  e_mem_re,
    input  logic                  m_reg_we,
    input  logic                  w_reg_we,
    output logic                  stall,
    output fwd_sel_e              fwd_a,
    output fwd_sel_e              fwd_b
);

    // newest producer wins, x0 never forwards
    function automatic fwd_sel_e fwd_pick(input logic [`RV_REG_AW-1:0] rs);
        if (rs == '0) begin
            return FWD_REG;
        end else if (m_reg_we && m_rd == rs) begin
            return FWD_MEM;
        end else if (w_reg_we && w_rd == rs) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    // load in execute feeding the instruction in decode
    assign stall = e_mem_re && (e_rd != '0) && ((e_rd == d_rs1) || (e_rd == d_rs2));

    always_comb begin
        fwd_a = fwd_pick(e_rs1);
        fwd_b = fwd_pick(e_rs2);
    end

endmodule

//--- hw/rv_pkg.sv
`include "rv_defines.svh"

package rv_pkg;

    // ----------------------------------------
    // instruction formats, all views of one word
    // ----------------------------------------
    typedef struct packed {
        logic [6:0]             funct7;
        logic [`RV_REG_AW-1:0]  rs2;
        logic [`RV_REG_AW-1:0]  rs1;
        logic [2:0]             funct3;
        logic [`RV_REG_AW-1:0]  rd;
        logic [6:0]             opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]            imm;
        logic [`RV_REG_AW-1:0]  rs1;
        logic [2:0]             funct3;
        logic [`RV_REG_AW-1:0]  rd;
        logic [6:0]             opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]             imm_hi;
        logic [`RV_REG_AW-1:0]  rs2;
        logic [`RV_REG_AW-1:0]  rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm_lo;
        logic [6:0]             opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                   imm12;
        logic [5:0]             imm10_5;
        logic [`RV_REG_AW-1:0]  rs2;
        logic [`RV_REG_AW-1:0]  rs1;
        logic [2:0]             funct3;
        logic [3:0]             imm4_1;
        logic                   imm11;
        logic [6:0]             opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]            imm31_12;
        logic [`RV_REG_AW-1:0]  rd;
        logic [6:0]             opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                   imm20;
        logic [9:0]             imm10_1;
        logic                   imm11;
        logic [7:0]             imm19_12;
        logic [`RV_REG_AW-1:0]  rd;
        logic [6:0]             opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG, // value read in decode
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;   // operand b is the immediate
        logic    reg_we;
        logic    mem_we;
        logic    mem_re;
        logic    is_branch;
        logic    branch_ne; // bne, else beq
        logic    is_jal;
        logic    is_lui;
    } ctrl_t;

    // ----------------------------------------
    // stage buffers
    // ----------------------------------------
    typedef struct packed {
        logic                   valid;
        logic [`RV_XLEN-1:0]    pc;
        logic [`RV_REG_AW-1:0]  rs1;
        logic [`RV_REG_AW-1:0]  rs2;
        logic [`RV_REG_AW-1:0]  rd;
        logic [`RV_XLEN-1:0]    rdata1;
        logic [`RV_XLEN-1:0]    rdata2;
        logic [`RV_XLEN-1:0]    imm;
        ctrl_t                  ctrl;
    } de_bus_t;

    typedef struct packed {
        logic                   valid;
        logic [`RV_XLEN-1:0]    pc;
        logic [`RV_REG_AW-1:0]  rd;
        logic [`RV_XLEN-1:0]    result;     // alu result or memory address
        logic [`RV_XLEN-1:0]    store_data;
        logic                   reg_we;
        logic                   mem_we;
        logic                   mem_re;
    } em_bus_t;

    typedef struct packed {
        logic                   valid;
        logic [`RV_XLEN-1:0]    pc;
        logic [`RV_REG_AW-1:0]  rd;
        logic [`RV_XLEN-1:0]    result;
        logic [`RV_XLEN-1:0]    load_data;
        logic                   reg_we;
        logic                   mem_re;
    } mw_bus_t;

endpackage

//--- hw/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`RV_REG_AW-1:0] raddr1,
    input  logic [`RV_REG_AW-1:0] raddr2,
    output logic [`RV_XLEN-1:0]   rdata1,
    output logic [`RV_XLEN-1:0]   rdata2,
    input  logic                  we,
    input  logic [`RV_REG_AW-1:0] waddr,
    input  logic [`RV_XLEN-1:0]   wdata
);

    logic [`RV_XLEN-1:0] regs [1:31];

    // x0 is hardwired, a same-cycle write is passed straight through
    function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_AW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (we && waddr == addr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regs <= '{default: '0};
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

endmodule

//--- hw/rv_writeback.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_writeback import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  em_bus_t               em_bus,
    input  logic [`RV_XLEN-1:0]   load_data,
    output logic                  reg_we,
    output logic [`RV_REG_AW-1:0] rd,
    output logic [`RV_XLEN-1:0]   wdata,
    output logic                  retire_valid,
    output logic [`RV_XLEN-1:0]   retire_pc
);

    mw_bus_t mw_bus;

    // memory to writeback buffer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mw_bus <= '0;
        end else begin
            mw_bus.valid     <= em_bus.valid;
            mw_bus.pc        <= em_bus.pc;
            mw_bus.rd        <= em_bus.rd;
            mw_bus.result    <= em_bus.result;
            mw_bus.load_data <= load_data;
            mw_bus.reg_we    <= em_bus.reg_we;
            mw_bus.mem_re    <= em_bus.mem_re;
        end
    end

    assign wdata  = mw_bus.mem_re ? mw_bus.load_data : mw_bus.result;
    assign rd     = mw_bus.rd;
    assign reg_we = mw_bus.valid && mw_bus.reg_we && (mw_bus.rd != '0); // x0 never written

    assign retire_valid = mw_bus.valid;
    assign retire_pc    = mw_bus.pc;

endmodule

//--- project.f
+incdir+hw
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_regfile.sv
hw/rv_decode.sv
hw/rv_hazard.sv
hw/rv_execute.sv
hw/rv_writeback.sv
hw/rv_core.sv
testbench/rv_core_checker.sv
testbench/rv_core_tb.sv

//--- testbench/rv_core_checker.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_core_checker #(
    parameter int LINK_RD = 9,   // only jal writes this register
    parameter int SKIP_RD = 31   // only the flushed addi write this one
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`RV_XLEN-1:0]   imem_addr,
    input  logic                  dmem_we,
    input  logic                  dmem_re,
    input  logic                  retire_valid,
    input  logic [`RV_XLEN-1:0]   retire_pc,
    input  logic                  retire_we,
    input  logic [`RV_REG_AW-1:0] retire_rd,
    input  logic [`RV_XLEN-1:0]   retire_data
);

    int reset_fails = 0;
    int flush_fails = 0;
    int link_fails  = 0;

    // ----------------------------------------
    // port rules
    // ----------------------------------------
    property quiet_in_reset;
        @(posedge clk) (rst || $past(rst)) |->
            (!retire_valid && !dmem_we && !dmem_re && imem_addr == `RV_RESET_PC);
    endproperty

    property no_flushed_write;
        @(posedge clk) disable iff (rst)
            (retire_valid && retire_we) |-> (retire_rd != 5'(SKIP_RD));
    endproperty

    // link value is the address after the jal
    property link_is_next_pc;
        @(posedge clk) disable iff (rst)
            (retire_valid && retire_we && retire_rd == 5'(LINK_RD)) |->
                (retire_data == retire_pc + `RV_XLEN'd4);
    endproperty

    reset_quiet_a: assert property (quiet_in_reset) else begin
        reset_fails++;
        $error("core output active during or right after reset");
    end

    flush_a: assert property (no_flushed_write) else begin
        flush_fails++;
        $error("an instruction behind a taken branch or jal retired");
    end

    link_a: assert property (link_is_next_pc) else begin
        link_fails++;
        $error("retire_data = %h, expected %h", retire_data, retire_pc + 4);
    end

endmodule

//--- testbench/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_core_tb;

    localparam int          CLK_PERIOD  = 100;
    localparam int          PROG_LEN    = 22;
    localparam int          WATCHDOG_NS = 200 * PROG_LEN * CLK_PERIOD;
    localparam logic [31:0] DATA_BASE   = 32'h100;
    localparam logic [31:0] JAL_PC      = 32'd68;
    localparam logic [31:0] FALL_PC     = 32'd80;  // addi behind the untaken bne

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] imem_addr, imem_data;
    logic [31:0] dmem_addr, dmem_wdata, dmem_rdata;
    logic        dmem_we, dmem_re;
    logic        retire_valid, retire_we;
    logic [31:0] retire_pc, retire_data;
    logic [4:0]  retire_rd;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:1023];
    logic [31:0] exp_pcs [$];       // retire order along the control flow
    logic [31:0] a_val, b_val;
    int          prog_len   = 0;
    int          retire_n   = 0;
    int          order_errs = 0;
    int          pass_cnt   = 0;
    int          fail_cnt   = 0;
    bit          fall_seen  = 1'b0;
    bit          link_seen  = 1'b0;
    bit          prog_done  = 1'b0;

    rv_core rv_core_inst (
        .clk          (clk),
        .rst          (rst),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .dmem_addr    (dmem_addr),
        .dmem_wdata   (dmem_wdata),
        .dmem_we      (dmem_we),
        .dmem_re      (dmem_re),
        .dmem_rdata   (dmem_rdata),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    bind rv_core rv_core_checker rv_core_checker_inst (
        .clk          (clk),
        .rst          (rst),
        .imem_addr    (imem_addr),
        .dmem_we      (dmem_we),
        .dmem_re      (dmem_re),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ----------------------------------------
    // memory models
    // ----------------------------------------
    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[11:2]]; // same-cycle read

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[11:2]] <= dmem_wdata;
        end
    end

    // ----------------------------------------
    // instruction encoding
    // ----------------------------------------
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE}; // sw
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, `RV_OP_LUI};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
    endfunction

    task automatic emit(input logic [31:0] word, input bit retires);
        imem[prog_len] = word;
        if (retires) begin
            exp_pcs.push_back(32'(prog_len * 4));
        end
        prog_len++;
    endtask

    task automatic build_program();
        logic [31:0] hi_a;
        logic [31:0] hi_b;
        int          i;
        hi_a = (a_val + 32'h800) >> 12; // rounds up when the low part is negative
        hi_b = (b_val + 32'h800) >> 12;
        for (i = 0; i < 256; i++) begin
            imem[i] = {i[24:0], 7'b0000000}; // opcode zero decodes as a bubble
        end
        for (i = 0; i < 1024; i++) begin
            dmem[i] = 32'hc0de_0000 ^ (i * 32'h0001_0003);
        end
        emit(u_type(hi_a[19:0], 5'd1), 1);
        emit(i_type(a_val[11:0], 5'd1, `RV_F3_ADD, 5'd1, `RV_OP_IMM), 1);
        emit(u_type(hi_b[19:0], 5'd2), 1);
        emit(i_type(b_val[11:0], 5'd2, `RV_F3_ADD, 5'd2, `RV_OP_IMM), 1);
        emit(r_type(7'h00, 5'd2, 5'd1, `RV_F3_ADD, 5'd3), 1);
        emit(r_type(7'h20, 5'd2, 5'd3, `RV_F3_ADD, 5'd4), 1);   // sub
        emit(r_type(7'h00, 5'd2, 5'd1, `RV_F3_XOR, 5'd5), 1);
        emit(r_type(7'h00, 5'd2, 5'd1, `RV_F3_SLT, 5'd6), 1);
        emit(s_type(12'h100, 5'd3, 5'd0), 1);
        emit(s_type(12'h104, 5'd4, 5'd0), 1);
        emit(s_type(12'h108, 5'd5, 5'd0), 1);
        emit(s_type(12'h10c, 5'd6, 5'd0), 1);
        emit(i_type(12'h100, 5'd0, 3'b010, 5'd7, `RV_OP_LOAD), 1); // lw
        emit(r_type(7'h00, 5'd7, 5'd7, `RV_F3_ADD, 5'd8), 1);  // load-use
        emit(s_type(12'h110, 5'd8, 5'd0), 1);
        emit(b_type(13'd8, 5'd1, 5'd1, `RV_F3_BEQ), 1);        // taken
        emit(i_type(12'd1, 5'd0, `RV_F3_ADD, 5'd31, `RV_OP_IMM), 0);
        emit(j_type(21'd8, 5'd9), 1);
        emit(i_type(12'd2, 5'd0, `RV_F3_ADD, 5'd31, `RV_OP_IMM), 0);
        emit(b_type(13'd8, 5'd1, 5'd1, `RV_F3_BNE), 1);        // not taken
        emit(i_type(12'd3, 5'd0, `RV_F3_ADD, 5'd10, `RV_OP_IMM), 1);
        emit(j_type(21'd0, 5'd0), 1); // park here
    endtask

    task automatic check_mem(input logic [31:0] addr, input logic [31:0] expected,
                             inout int errs);
        assert (dmem[addr[11:2]] == expected) else begin
            $display("** Error at %0t ns: dmem[%h] = %h, expected %h",
                     $time, addr, dmem[addr[11:2]], expected);
            errs++;
        end
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            pass_cnt++;
            $display("test %s: pass", name);
        end else begin
            fail_cnt++;
            $display("test %s: fail, %0d errors", name, errs);
        end
    endtask

    // retire monitor, sampled away from the active edge
    always @(negedge clk) begin
        if (!rst && retire_valid && !prog_done) begin
            assert (retire_pc == exp_pcs[retire_n]) else begin
                $display("** Error at %0t ns: retire_pc = %h, expected %h",
                         $time, retire_pc, exp_pcs[retire_n]);
                order_errs++;
            end
            if (retire_pc == FALL_PC && retire_we && retire_rd == 5'd10
                    && retire_data == 32'd3) begin
                fall_seen = 1'b1;
            end
            if (retire_pc == JAL_PC && retire_we && retire_rd == 5'd9
                    && retire_data == JAL_PC + 32'd4) begin
                link_seen = 1'b1;
            end
            retire_n++;
            if (retire_n == exp_pcs.size()) begin
                prog_done = 1'b1;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, program never finished retiring", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int errs;
        rst <= 1'b1; // seen as an edge by the async reset
        void'($urandom(78684));
        a_val = $urandom();
        b_val = $urandom();
        build_program();
        repeat (4) @(posedge clk);
        #5 rst = 1'b0;
        @(posedge clk);
        #5;
        report_test("reset", rv_core_inst.rv_core_checker_inst.reset_fails);

        wait (prog_done);
        repeat (3) @(posedge clk);

        errs = 0;
        check_mem(DATA_BASE, a_val + b_val, errs);
        check_mem(DATA_BASE + 4, a_val, errs);
        check_mem(DATA_BASE + 8, a_val ^ b_val, errs);
        check_mem(DATA_BASE + 12, {31'b0, $signed(a_val) < $signed(b_val)}, errs);
        report_test("forwarding", errs);

        errs = 0;
        check_mem(DATA_BASE + 16, (a_val + b_val) << 1, errs);
        report_test("load-use", errs);

        errs = rv_core_inst.rv_core_checker_inst.flush_fails;
        assert (fall_seen) else begin
            $display("instruction after the untaken bne never retired with x10 = 3");
            errs++;
        end
        report_test("flush", errs);

        errs = order_errs + rv_core_inst.rv_core_checker_inst.link_fails;
        assert (link_seen) else begin
            $display("jal writing x9 never retired with the address after it");
            errs++;
        end
        report_test("link and order", errs);

        $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
